//--- fdiv_pkg.sv
package fdiv_pkg;

  // binary32 field layout
  localparam int EXP_W   = 8;
  localparam int FRAC_W  = 23;
  localparam int MANT_W  = FRAC_W + 1;          // fraction plus explicit leading bit
  localparam int BIAS    = 127;
  localparam int EXP_MAX = 255;                 // all-ones biased exponent

  // integer bit, 23 fraction bits, two spare bits for the normalize shift
  localparam int QUO_W = 26;

  typedef logic [31:0] float_t;
  typedef logic signed [9:0] exp_t;             // room for the tentative quotient exponent
  typedef logic [MANT_W-1:0] mant_t;
  typedef logic [QUO_W-1:0] quo_t;

  typedef enum logic [1:0] {
    SP_NONE,
    SP_NAN,
    SP_INF,
    SP_ZERO
  } fdiv_special_t;

  typedef struct packed {
    logic          sign;                        // xor of the operand signs
    exp_t          exp;                         // biased, before normalization
    mant_t         dividend;                    // top bit set unless operand is zero
    mant_t         divisor;
    fdiv_special_t special;
  } fdiv_op_t;

  typedef enum logic [1:0] {
    IDLE,
    DIVIDE,
    PACK,
    DONE
  } fdiv_state_t;

  localparam float_t QNAN    = 32'h7fc00000;
  localparam float_t POS_INF = 32'h7f800000;

endpackage

//--- fdiv_unpack.sv
`timescale 1ns/1ns

module fdiv_unpack (
  input  logic               clk,
  input  logic               load,
  input  fdiv_pkg::float_t   rs1,
  input  fdiv_pkg::float_t   rs2,
  output fdiv_pkg::fdiv_op_t op
);

  localparam int EXP_W_L = fdiv_pkg::EXP_W;

  function automatic logic [EXP_W_L-1:0] exp_field(input fdiv_pkg::float_t f);
    return f[fdiv_pkg::FRAC_W +: fdiv_pkg::EXP_W];
  endfunction

  // subnormals get a zero hidden bit
  function automatic fdiv_pkg::mant_t mant_of(input fdiv_pkg::float_t f);
    return {exp_field(f) != '0, f[fdiv_pkg::FRAC_W-1:0]};
  endfunction

  // subnormals behave as exponent 1
  function automatic fdiv_pkg::exp_t exp_of(input fdiv_pkg::float_t f);
    logic [EXP_W_L-1:0] e;
    e = exp_field(f);
    if (e == '0)
      e = 1;
    return fdiv_pkg::exp_t'(e);
  endfunction

  function automatic logic [4:0] lead_zeros(input fdiv_pkg::mant_t m);
    logic [4:0] n;
    n = 5'd24;
    for (int i = 0; i < fdiv_pkg::MANT_W; i++) begin
      if (m[i])
        n = 5'(fdiv_pkg::MANT_W - 1 - i);     // highest set bit wins
    end
    return n;
  endfunction

  fdiv_pkg::mant_t         m1, m2;
  logic [4:0]              lz1, lz2;
  fdiv_pkg::exp_t          x1, x2;
  logic                    zero1, zero2, inf1, inf2, nan1, nan2;
  fdiv_pkg::fdiv_special_t special;

  assign m1  = mant_of(rs1);
  assign m2  = mant_of(rs2);
  assign lz1 = lead_zeros(m1);
  assign lz2 = lead_zeros(m2);
  assign x1  = exp_of(rs1) - fdiv_pkg::exp_t'(lz1);  // exponent after prenormalize
  assign x2  = exp_of(rs2) - fdiv_pkg::exp_t'(lz2);

  assign zero1 = exp_field(rs1) == '0 && rs1[fdiv_pkg::FRAC_W-1:0] == '0;
  assign zero2 = exp_field(rs2) == '0 && rs2[fdiv_pkg::FRAC_W-1:0] == '0;
  assign inf1  = exp_field(rs1) == EXP_W_L'(fdiv_pkg::EXP_MAX) && rs1[fdiv_pkg::FRAC_W-1:0] == '0;
  assign inf2  = exp_field(rs2) == EXP_W_L'(fdiv_pkg::EXP_MAX) && rs2[fdiv_pkg::FRAC_W-1:0] == '0;
  assign nan1  = exp_field(rs1) == EXP_W_L'(fdiv_pkg::EXP_MAX) && !inf1;
  assign nan2  = exp_field(rs2) == EXP_W_L'(fdiv_pkg::EXP_MAX) && !inf2;

  always_comb begin
    if (nan1 || nan2 || (inf1 && inf2) || (zero1 && zero2))
      special = fdiv_pkg::SP_NAN;
    else if (inf1 || zero2)
      special = fdiv_pkg::SP_INF;
    else if (zero1 || inf2)
      special = fdiv_pkg::SP_ZERO;
    else
      special = fdiv_pkg::SP_NONE;
  end

  always_ff @(posedge clk) begin
    if (load) begin
      op.sign     <= rs1[31] ^ rs2[31];
      op.exp      <= x1 - x2 + fdiv_pkg::exp_t'(fdiv_pkg::BIAS);
      op.dividend <= m1 << lz1;
      op.divisor  <= m2 << lz2;
      op.special  <= special;
    end
  end

endmodule

//--- fdiv_mant_div.sv
`timescale 1ns/1ns

module fdiv_mant_div #(
  parameter int BITS_PER_CYCLE = 1
) (
  input  logic               clk,
  input  logic               load,
  input  logic               step,
  input  fdiv_pkg::fdiv_op_t op,
  output fdiv_pkg::quo_t     quo
);

  localparam int QW    = fdiv_pkg::QUO_W;
  localparam int REM_W = fdiv_pkg::MANT_W + 1;  // remainder is doubled after each bit

  typedef logic [REM_W-1:0] rem_t;

  rem_t           rem;
  rem_t           rem_nxt;
  fdiv_pkg::quo_t quo_nxt;
  logic           first;                        // next step starts from the dividend

  // BITS_PER_CYCLE restoring iterations per step
  always_comb begin
    rem_t           r;
    rem_t           d;
    fdiv_pkg::quo_t q;
    d = rem_t'(op.divisor);
    r = first ? rem_t'(op.dividend) : rem;
    q = quo;
    for (int i = 0; i < BITS_PER_CYCLE; i++) begin
      if (r >= d) begin
        r = r - d;
        q = {q[QW-2:0], 1'b1};
      end else begin
        q = {q[QW-2:0], 1'b0};
      end
      r = r << 1;
    end
    rem_nxt = r;
    quo_nxt = q;
  end

  // op is only registered on the load edge, so the remainder picks up the
  // dividend in the first DIVIDE cycle
  always_ff @(posedge clk) begin
    if (load) begin
      quo   <= '0;
      first <= 1'b1;
    end else if (step) begin
      rem   <= rem_nxt;
      quo   <= quo_nxt;
      first <= 1'b0;
    end
  end

  // unpack flags every zero divisor as a special case
  assert property (@(posedge clk)
    step && op.special == fdiv_pkg::SP_NONE |-> op.divisor != '0)
    else $error("zero divisor reached the divider without a special class");

endmodule

//--- fdiv_norm_pack.sv
`timescale 1ns/1ns

module fdiv_norm_pack (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               pack,
  input  fdiv_pkg::fdiv_op_t op,
  input  fdiv_pkg::quo_t     quo,
  output fdiv_pkg::float_t   rd
);

  localparam int QW = fdiv_pkg::QUO_W;

  fdiv_pkg::quo_t   quo_n;
  fdiv_pkg::exp_t   exp_n;
  fdiv_pkg::mant_t  mant_n;
  fdiv_pkg::mant_t  mant_sub;
  logic [9:0]       sub_shift;
  fdiv_pkg::float_t result;

  // quotient of two normalized mantissas is in [0.5, 2)
  assign quo_n  = quo[QW-1] ? quo : quo << 1;
  assign exp_n  = quo[QW-1] ? op.exp : op.exp - fdiv_pkg::exp_t'(1);
  assign mant_n = quo_n[QW-1 -: fdiv_pkg::MANT_W];  // low bits dropped, truncation

  // denormalize, large shifts leave zero
  assign sub_shift = 10'(fdiv_pkg::exp_t'(1) - exp_n);
  assign mant_sub  = mant_n >> sub_shift;

  always_comb begin
    case (op.special)
      fdiv_pkg::SP_NAN:  result = fdiv_pkg::QNAN;
      fdiv_pkg::SP_INF:  result = {op.sign, fdiv_pkg::POS_INF[30:0]};
      fdiv_pkg::SP_ZERO: result = {op.sign, 31'b0};
      default: begin
        if (exp_n >= fdiv_pkg::exp_t'(fdiv_pkg::EXP_MAX))
          result = {op.sign, fdiv_pkg::POS_INF[30:0]};  // overflow
        else if (exp_n <= 0)
          result = {op.sign, fdiv_pkg::EXP_W'(0), mant_sub[fdiv_pkg::FRAC_W-1:0]};
        else
          result = {op.sign, exp_n[fdiv_pkg::EXP_W-1:0], mant_n[fdiv_pkg::FRAC_W-1:0]};
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      rd <= '0;
    else if (pack)
      rd <= result;
  end

  // the divider must have left a one in the top two quotient bits
  assert property (@(posedge clk) disable iff (!rst_n)
    pack && op.special == fdiv_pkg::SP_NONE |-> quo[QW-1 -: 2] != 2'b00)
    else $error("quotient out of range at pack");

endmodule

//--- fdiv_ctrl.sv
`timescale 1ns/1ns

module fdiv_ctrl #(
  parameter int BITS_PER_CYCLE = 1
) (
  input  logic clk,
  input  logic rst_n,
  input  logic req_valid,
  output logic req_ready,
  output logic resp_valid,
  input  logic resp_ready,
  output logic load,
  output logic step,
  output logic pack
);

  localparam int STEPS = fdiv_pkg::QUO_W / BITS_PER_CYCLE;
  localparam int CNT_W = $clog2(STEPS);

  fdiv_pkg::fdiv_state_t state;
  logic [CNT_W-1:0]      cnt;                   // divide steps done so far

  assign req_ready  = state == fdiv_pkg::IDLE;
  assign resp_valid = state == fdiv_pkg::DONE;
  assign load       = req_valid && req_ready;   // accept edge
  assign step       = state == fdiv_pkg::DIVIDE;
  assign pack       = state == fdiv_pkg::PACK;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= fdiv_pkg::IDLE;
      cnt   <= '0;
    end else begin
      case (state)
        fdiv_pkg::IDLE: begin
          cnt <= '0;
          if (req_valid)
            state <= fdiv_pkg::DIVIDE;
        end
        fdiv_pkg::DIVIDE: begin
          cnt <= cnt + 1'b1;
          if (cnt == CNT_W'(STEPS - 1))
            state <= fdiv_pkg::PACK;
        end
        fdiv_pkg::PACK: begin
          state <= fdiv_pkg::DONE;
        end
        fdiv_pkg::DONE: begin
          if (resp_ready)
            state <= fdiv_pkg::IDLE;    // back-pressure holds us here
        end
        default: begin
          state <= fdiv_pkg::IDLE;
        end
      endcase
    end
  end

  initial begin
    assert (fdiv_pkg::QUO_W % BITS_PER_CYCLE == 0)
      else $error("BITS_PER_CYCLE must divide the quotient width");
  end

  // a response only follows a pack cycle and blocks new requests
  assert property (@(posedge clk) disable iff (!rst_n)
    $rose(resp_valid) |-> $past(pack) && state == fdiv_pkg::DONE && !req_ready)
    else $error("response raised outside DONE");

  assert property (@(posedge clk) disable iff (!rst_n) !(load && step))
    else $error("load and step overlap");

endmodule

//--- fdiv_top.sv
`timescale 1ns/1ns

module fdiv_top #(
  parameter int BITS_PER_CYCLE = 1
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             req_valid,
  output logic             req_ready,
  input  fdiv_pkg::float_t rs1,
  input  fdiv_pkg::float_t rs2,
  output logic             resp_valid,
  input  logic             resp_ready,
  output fdiv_pkg::float_t rd
);

  logic               load;
  logic               step;
  logic               pack;
  fdiv_pkg::fdiv_op_t op;
  fdiv_pkg::quo_t     quo;

  fdiv_ctrl #(
    .BITS_PER_CYCLE(BITS_PER_CYCLE)
  ) fdiv_ctrl_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .load       (load),
    .step       (step),
    .pack       (pack)
  );

  fdiv_unpack fdiv_unpack_i (
    .clk  (clk),
    .load (load),
    .rs1  (rs1),
    .rs2  (rs2),
    .op   (op)
  );

  fdiv_mant_div #(
    .BITS_PER_CYCLE(BITS_PER_CYCLE)
  ) fdiv_mant_div_i (
    .clk  (clk),
    .load (load),
    .step (step),
    .op   (op),
    .quo  (quo)
  );

  fdiv_norm_pack fdiv_norm_pack_i (
    .clk   (clk),
    .rst_n (rst_n),
    .pack  (pack),
    .op    (op),
    .quo   (quo),
    .rd    (rd)
  );

  // a stalled response keeps the FSM in DONE and the result steady
  assert property (@(posedge clk) disable iff (!rst_n)
    resp_valid && !resp_ready |=> fdiv_ctrl_i.state == fdiv_pkg::DONE && $stable(rd))
    else $error("rd changed under back-pressure");

endmodule

//--- tb_fdiv_vectors.svh
`ifndef TB_FDIV_VECTORS_SVH
`define TB_FDIV_VECTORS_SVH

// one row per division: dividend, divisor, expected quotient (round toward zero)
typedef struct packed {
  fdiv_pkg::float_t a;
  fdiv_pkg::float_t b;
  fdiv_pkg::float_t expected;
} vector_t;

localparam int NUM_VECTORS = 11;

vector_t vectors [NUM_VECTORS] = '{
  '{32'h3f800000, 32'h3f800000, 32'h3f800000},    // 1 / 1
  '{32'h40c00000, 32'h40400000, 32'h40000000},    // 6 / 3
  '{32'hc1000000, 32'h40000000, 32'hc0800000},    // -8 / 2
  '{32'h3f800000, 32'h40400000, 32'h3eaaaaaa},    // last fraction bit dropped, not rounded up
  '{32'h3f800000, 32'h00000000, fdiv_pkg::POS_INF},
  '{32'h00000000, 32'h00000000, fdiv_pkg::QNAN},
  '{32'h7f800000, 32'h7f800000, fdiv_pkg::QNAN},
  '{32'h80000000, 32'h3f800000, 32'h80000000},
  '{32'h7f000000, 32'h3e800000, fdiv_pkg::POS_INF},  // 2^127 / 2^-2
  '{32'h00800000, 32'h40000000, 32'h00400000},    // smallest normal halved
  '{32'h00000001, 32'h00000001, 32'h3f800000}     // both operands subnormal
};

string vector_names [NUM_VECTORS] = '{
  "one_by_one",
  "six_by_three",
  "neg_eight_by_two",
  "one_by_three_truncated",
  "one_by_zero",
  "zero_by_zero",
  "inf_by_inf",
  "neg_zero_by_one",
  "overflow_to_inf",
  "subnormal_result",
  "subnormal_inputs"
};

`endif

//--- tb_fdiv.sv
`timescale 1ns/1ns

module tb_fdiv;

  localparam int BITS_PER_CYCLE = 1;
  localparam int CLK_PERIOD     = 100;
  localparam int RESET_CYCLES   = 3;
  localparam int DRIVE_DELAY    = 1;
  localparam int LATENCY        = fdiv_pkg::QUO_W / BITS_PER_CYCLE + 2;  // accept edge to response

  `include "tb_fdiv_vectors.svh"

  localparam int WATCHDOG_NS = NUM_VECTORS * (LATENCY + 8 + 4) * CLK_PERIOD * 2;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic             req_ready;
  fdiv_pkg::float_t rs1;
  fdiv_pkg::float_t rs2;
  logic             resp_valid;
  logic             resp_ready;
  fdiv_pkg::float_t rd;

  logic [31:0] lfsr;
  int          pass_count;
  int          fail_count;
  int          test_errors;

  fdiv_top #(
    .BITS_PER_CYCLE(BITS_PER_CYCLE)
  ) fdiv_top_i (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .rs1        (rs1),
    .rs2        (rs2),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready),
    .rd         (rd)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("watchdog expired: the divider hung and never finished the test sequence");
    $display("tests failed");
    $finish;
  end

  // fibonacci form, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  task automatic pick_stall(output int cycles);
    logic [2:0] bits;
    bits = '0;
    for (int i = 0; i < 3; i++) begin
      lfsr = lfsr_step(lfsr);               // one step per bit
      bits = {bits[1:0], lfsr[0]};
    end
    cycles = int'(bits);
  endtask

  // inputs change and outputs are read just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #(DRIVE_DELAY);
  endtask

  task automatic report_error(input string what);
    $display("ERROR: %s", what);
    test_errors++;
  endtask

  task automatic close_test(input string name);
    if (test_errors == 0) begin
      $display("PASS  %s", name);
      pass_count++;
    end else begin
      $display("FAIL  %s (%0d errors)", name, test_errors);
      fail_count++;
    end
    test_errors = 0;
  endtask

  task automatic run_vector(input vector_t v, input string name);
    int               stall;
    int               waited;
    logic             busy_ready_seen;
    fdiv_pkg::float_t held;
    pick_stall(stall);
    busy_ready_seen = 1'b0;
    rs1        = v.a;
    rs2        = v.b;
    req_valid  = 1'b1;
    resp_ready = 1'b0;
    while (!req_ready)
      next_cycle();
    next_cycle();                           // accept edge
    req_valid = 1'b0;
    waited    = 1;                          // edges until resp_valid is sampled high
    while (!resp_valid) begin
      if (req_ready)
        busy_ready_seen = 1'b1;
      next_cycle();
      waited++;
    end
    if (busy_ready_seen)
      report_error($sformatf("%s: req_ready went high before the response", name));
    if (waited != LATENCY)
      report_error($sformatf("%s: response after %0d cycles instead of %0d",
                             name, waited, LATENCY));
    held = rd;
    repeat (stall) begin
      next_cycle();
      if (!resp_valid)
        report_error($sformatf("%s: resp_valid dropped while resp_ready was low", name));
      if (rd !== held)
        report_error($sformatf("%s: rd changed while the response was stalled", name));
      if (req_ready)
        report_error($sformatf("%s: req_ready high while the response was stalled", name));
    end
    held       = rd;                        // value seen by the handshake edge
    resp_ready = 1'b1;
    next_cycle();
    resp_ready = 1'b0;
    if (held !== v.expected) begin
      $display("MISMATCH %s: expected %08h, actual %08h", name, v.expected, held);
      test_errors++;
    end
    if (resp_valid || !req_ready)
      report_error($sformatf("%s: unit did not return to idle after the response", name));
  endtask

  initial begin
    rst_n       = 1'b0;
    req_valid   = 1'b0;
    resp_ready  = 1'b0;
    rs1         = '0;
    rs2         = '0;
    lfsr        = 32'hfbe649eb;
    pass_count  = 0;
    fail_count  = 0;
    test_errors = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    if (req_ready !== 1'b1 || resp_valid !== 1'b0)
      report_error($sformatf("after reset req_ready=%b resp_valid=%b, expected 1 and 0",
                             req_ready, resp_valid));
    close_test("reset_state");
    for (int i = 0; i < NUM_VECTORS; i++) begin
      run_vector(vectors[i], vector_names[i]);
      close_test(vector_names[i]);
    end
    $display("summary: %0d run, %0d passed, %0d failed",
             pass_count + fail_count, pass_count, fail_count);
    if (fail_count == 0)
      $display("all tests passed");
    else
      $display("tests failed");
    $finish;
  end

endmodule

//--- build.f
+incdir+.
fdiv_pkg.sv
fdiv_unpack.sv
fdiv_mant_div.sv
fdiv_norm_pack.sv
fdiv_ctrl.sv
fdiv_top.sv
tb_fdiv.sv

//--- Makefile
# Verilator build and run for the floating-point divider testbench

VERILATOR ?= verilator
TOP       ?= tb_fdiv
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= all tests passed

SOURCES := $(wildcard *.sv) $(wildcard *.svh)
BINARY  := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(BINARY) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
